//--- rtl/router_geom_pkg.sv
`default_nettype none

// router geometry shared by all vc bookkeeping blocks
// every per-vc vector is indexed port * num_vcs + vc
package router_geom_pkg;

    localparam int num_ports = 5;  // port 0 is the local port
    localparam int num_vcs   = 4;  // vcs per port

    // total vc count over the router
    localparam int pv = num_ports * num_vcs;

    // one-hot vc number carried for every vc
    localparam int pvv = pv * num_vcs;

    // destination port is one-hot over the other ports only,
    // own port skipped, rising port order
    localparam int dst_w = num_ports - 1;

    // all destination-port vectors side by side
    localparam int pv_dst_w = pv * dst_w;

endpackage

`default_nettype wire

//--- rtl/flow_ctrl_pkg.sv
`default_nettype none

// credit flow control between this router and its downstream buffers
package flow_ctrl_pkg;

    // flits per downstream vc buffer
    localparam int buf_depth = 4;

    // occupancy counter must hold the full value buf_depth
    localparam int depth_w = $clog2(buf_depth) + 1;

    // one slot left, an output vc at this level takes no new packet
    // and no more flits from a switch grant
    localparam logic [depth_w-1:0] nearly_full_lvl = depth_w'(buf_depth - 1);

endpackage

`default_nettype wire

//--- rtl/ivc_assign_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ivc_assign_ctrl (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [router_geom_pkg::pv-1:0]       ivc_num_getting_ovc_grant,
    input  wire  [router_geom_pkg::pv-1:0]       ivc_num_getting_sw_grant,
    input  wire  [router_geom_pkg::pv-1:0]       flit_is_tail_all,
    input  wire  [router_geom_pkg::pvv-1:0]      granted_ovc_num_all,
    input  wire  [router_geom_pkg::pv_dst_w-1:0] dest_port_all,
    input  wire  [router_geom_pkg::pv-1:0]       nearly_full_all,
    output logic [router_geom_pkg::pv-1:0]       ovc_is_assigned_all,
    output logic [router_geom_pkg::pv-1:0]       credit_out_all,
    output wire  [router_geom_pkg::pv-1:0]       assigned_ovc_not_full_all,
    output logic [router_geom_pkg::pv-1:0]       ovc_sent_all,
    output logic [router_geom_pkg::pv-1:0]       ovc_released_all
);

    logic [router_geom_pkg::pvv-1:0] assigned_ovc_num;  // one-hot vc at the dest port
    wire  [router_geom_pkg::pv-1:0]  release_ivc;       // tail leaves, packet done

    // per input vc, one-hot over all output vcs of the router
    wire  [router_geom_pkg::pv-1:0]  ovc_target [router_geom_pkg::pv];

    assign release_ivc = ivc_num_getting_sw_grant & flit_is_tail_all;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ovc_is_assigned_all <= '0;
            credit_out_all      <= '0;
        end else begin
            credit_out_all      <= ivc_num_getting_sw_grant;  // one credit per flit out
            // release wins when it meets a grant on the same vc
            ovc_is_assigned_all <= (ovc_is_assigned_all | ivc_num_getting_ovc_grant)
                                   & ~release_ivc;
        end
    end

    // vc number latched together with the assigned flag
    always_ff @(posedge clk) begin
        for (int k = 0; k < router_geom_pkg::pv; k++) begin
            if (ivc_num_getting_ovc_grant[k]) begin
                assigned_ovc_num[k*router_geom_pkg::num_vcs +: router_geom_pkg::num_vcs] <=
                    granted_ovc_num_all[k*router_geom_pkg::num_vcs +: router_geom_pkg::num_vcs];
            end
        end
    end

    genvar k, a;
    generate
        for (k = 0; k < router_geom_pkg::pv; k++) begin : g_ivc
            for (a = 0; a < router_geom_pkg::num_ports; a++) begin : g_port
                if (a == k / router_geom_pkg::num_vcs) begin : g_own
                    // no u-turn to the own port
                    assign ovc_target[k][a*router_geom_pkg::num_vcs +: router_geom_pkg::num_vcs] =
                        '0;
                end else begin : g_other
                    // absolute port a sits at relative slot a or a-1
                    assign ovc_target[k][a*router_geom_pkg::num_vcs +: router_geom_pkg::num_vcs] =
                        {router_geom_pkg::num_vcs{dest_port_all[k*router_geom_pkg::dst_w +
                            ((a < k / router_geom_pkg::num_vcs) ? a : a - 1)]}}
                        & assigned_ovc_num[k*router_geom_pkg::num_vcs +: router_geom_pkg::num_vcs];
                end
            end

            // space left in the output vc this input vc holds
            assign assigned_ovc_not_full_all[k] = ovc_is_assigned_all[k]
                                                  & ~|(ovc_target[k] & nearly_full_all);
        end
    endgenerate

    // switch-granted input vcs mark their target output vc
    always_comb begin
        ovc_sent_all     = '0;
        ovc_released_all = '0;
        for (int k = 0; k < router_geom_pkg::pv; k++) begin
            if (ivc_num_getting_sw_grant[k]) begin
                ovc_sent_all = ovc_sent_all | ovc_target[k];
            end
            if (release_ivc[k]) begin
                ovc_released_all = ovc_released_all | ovc_target[k];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ovc_credit_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module ovc_credit_tracker (
    input  wire                           clk,
    input  wire                           reset,
    input  wire  [router_geom_pkg::pv-1:0] ovc_sent_all,
    input  wire  [router_geom_pkg::pv-1:0] ovc_released_all,
    input  wire  [router_geom_pkg::pv-1:0] credit_in_all,
    input  wire  [router_geom_pkg::pv-1:0] ovc_allocated_all,
    output logic [router_geom_pkg::pv-1:0] ovc_available_all,
    output logic [router_geom_pkg::pv-1:0] nearly_full_all
);

    // flits sitting in the downstream buffer of each output vc
    logic [flow_ctrl_pkg::depth_w-1:0] occupancy [router_geom_pkg::pv];

    logic [router_geom_pkg::pv-1:0] allocated;  // owned by some input vc

    // a send and a credit in the same cycle cancel out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int o = 0; o < router_geom_pkg::pv; o++) begin
                occupancy[o] <= '0;
            end
        end else begin
            for (int o = 0; o < router_geom_pkg::pv; o++) begin
                if (ovc_sent_all[o] && !credit_in_all[o]) begin
                    occupancy[o] <= occupancy[o] + 1'b1;
                end else if (!ovc_sent_all[o] && credit_in_all[o]) begin
                    occupancy[o] <= occupancy[o] - 1'b1;
                end
            end
        end
    end

    // tail release frees the output vc for the next packet
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            allocated <= '0;
        end else begin
            allocated <= (allocated | ovc_allocated_all) & ~ovc_released_all;
        end
    end

    always_comb begin
        for (int o = 0; o < router_geom_pkg::pv; o++) begin
            nearly_full_all[o]   = (occupancy[o] >= flow_ctrl_pkg::nearly_full_lvl);
            // free and with room for more than one flit
            ovc_available_all[o] = ~allocated[o]
                                   & (occupancy[o] < flow_ctrl_pkg::nearly_full_lvl);
        end
    end

endmodule

`default_nettype wire

//--- rtl/vc_request_mask.sv
`timescale 1ns/1ps
`default_nettype none

module vc_request_mask (
    input  wire [router_geom_pkg::pv-1:0]       ivc_request_all,
    input  wire [router_geom_pkg::pv-1:0]       ovc_is_assigned_all,
    input  wire [router_geom_pkg::pv-1:0]       ovc_available_all,
    input  wire [router_geom_pkg::pv_dst_w-1:0] dest_port_all,
    input  wire [router_geom_pkg::pvv-1:0]      candidate_ovc_all,
    output wire [router_geom_pkg::pvv-1:0]      masked_ovc_request_all
);

    wire [router_geom_pkg::pv-1:0] non_assigned_req;  // still waiting for an output vc

    // availability of the other ports, as seen from each input port
    wire [router_geom_pkg::dst_w*router_geom_pkg::num_vcs-1:0]
        avail_other [router_geom_pkg::num_ports];

    assign non_assigned_req = ivc_request_all & ~ovc_is_assigned_all;

    genvar i, r, k;
    generate
        for (i = 0; i < router_geom_pkg::num_ports; i++) begin : g_port
            for (r = 0; r < router_geom_pkg::dst_w; r++) begin : g_rel
                // relative slot r skips own port i
                assign avail_other[i][r*router_geom_pkg::num_vcs +: router_geom_pkg::num_vcs] =
                    ovc_available_all[((r < i) ? r : r + 1)*router_geom_pkg::num_vcs +:
                                      router_geom_pkg::num_vcs];
            end
        end

        for (k = 0; k < router_geom_pkg::pv; k++) begin : g_ivc
            logic [router_geom_pkg::num_vcs-1:0] avb_muxed;

            // one-hot mux on the destination port
            always_comb begin
                avb_muxed = '0;
                for (int d = 0; d < router_geom_pkg::dst_w; d++) begin
                    avb_muxed = avb_muxed
                        | ({router_geom_pkg::num_vcs{dest_port_all[k*router_geom_pkg::dst_w + d]}}
                        & avail_other[k / router_geom_pkg::num_vcs]
                                     [d*router_geom_pkg::num_vcs +: router_geom_pkg::num_vcs]);
                end
            end

            assign masked_ovc_request_all[k*router_geom_pkg::num_vcs +: router_geom_pkg::num_vcs] =
                {router_geom_pkg::num_vcs{non_assigned_req[k]}}
                & candidate_ovc_all[k*router_geom_pkg::num_vcs +: router_geom_pkg::num_vcs]
                & avb_muxed;  // candidates that are free right now
        end
    endgenerate

endmodule

`default_nettype wire

//--- rtl/vc_port_top.sv
`timescale 1ns/1ps
`default_nettype none

module vc_port_top (
    input  wire                                 clk,
    input  wire                                 reset,
    // from the vc/switch allocator
    input  wire  [router_geom_pkg::pv-1:0]       ivc_num_getting_ovc_grant,
    input  wire  [router_geom_pkg::pvv-1:0]      granted_ovc_num_all,
    input  wire  [router_geom_pkg::pv-1:0]       ivc_num_getting_sw_grant,
    input  wire  [router_geom_pkg::pv-1:0]       ovc_allocated_all,
    input  wire  [router_geom_pkg::pv-1:0]       credit_in_all,  // from downstream routers
    // from the input buffers
    input  wire  [router_geom_pkg::pv-1:0]       ivc_request_all,
    input  wire  [router_geom_pkg::pv_dst_w-1:0] dest_port_all,
    input  wire  [router_geom_pkg::pvv-1:0]      candidate_ovc_all,
    input  wire  [router_geom_pkg::pv-1:0]       flit_is_tail_all,
    output wire  [router_geom_pkg::pv-1:0]       credit_out_all,
    output wire  [router_geom_pkg::pv-1:0]       ovc_is_assigned_all,
    output wire  [router_geom_pkg::pv-1:0]       assigned_ovc_not_full_all,
    output wire  [router_geom_pkg::pv-1:0]       ovc_available_all,
    output wire  [router_geom_pkg::pvv-1:0]      masked_ovc_request_all
);

    wire [router_geom_pkg::pv-1:0] ovc_sent_all;
    wire [router_geom_pkg::pv-1:0] ovc_released_all;
    wire [router_geom_pkg::pv-1:0] nearly_full_all;

    ivc_assign_ctrl ivc_assign_ctrl_inst (
        .clk                       (clk),
        .reset                     (reset),
        .ivc_num_getting_ovc_grant (ivc_num_getting_ovc_grant),
        .ivc_num_getting_sw_grant  (ivc_num_getting_sw_grant),
        .flit_is_tail_all          (flit_is_tail_all),
        .granted_ovc_num_all       (granted_ovc_num_all),
        .dest_port_all             (dest_port_all),
        .nearly_full_all           (nearly_full_all),
        .ovc_is_assigned_all       (ovc_is_assigned_all),
        .credit_out_all            (credit_out_all),
        .assigned_ovc_not_full_all (assigned_ovc_not_full_all),
        .ovc_sent_all              (ovc_sent_all),
        .ovc_released_all          (ovc_released_all)
    );

    ovc_credit_tracker ovc_credit_tracker_inst (
        .clk               (clk),
        .reset             (reset),
        .ovc_sent_all      (ovc_sent_all),
        .ovc_released_all  (ovc_released_all),
        .credit_in_all     (credit_in_all),
        .ovc_allocated_all (ovc_allocated_all),
        .ovc_available_all (ovc_available_all),
        .nearly_full_all   (nearly_full_all)
    );

    // deterministic routing, dest port fixed per packet
    vc_request_mask vc_request_mask_inst (
        .ivc_request_all        (ivc_request_all),
        .ovc_is_assigned_all    (ovc_is_assigned_all),
        .ovc_available_all      (ovc_available_all),
        .dest_port_all          (dest_port_all),
        .candidate_ovc_all      (candidate_ovc_all),
        .masked_ovc_request_all (masked_ovc_request_all)
    );

endmodule

`default_nettype wire

//--- tb/vc_port_model.svh
`ifndef VC_PORT_MODEL_SVH
`define VC_PORT_MODEL_SVH

// shadow state of the vc bookkeeping, stepped once per clock
bit m_assigned [router_geom_pkg::pv];
int m_asg_vc   [router_geom_pkg::pv];  // vc number at the dest port
int m_dest_rel [router_geom_pkg::pv];  // relative dest port, held while assigned
int m_occ      [router_geom_pkg::pv];  // downstream occupancy per output vc
bit m_alloc    [router_geom_pkg::pv];
logic [router_geom_pkg::pv-1:0] m_credit_exp;

task automatic reset_model();
    for (int k = 0; k < router_geom_pkg::pv; k++) begin
        m_assigned[k] = 1'b0;
        m_asg_vc[k]   = 0;
        m_dest_rel[k] = 0;
        m_occ[k]      = 0;
        m_alloc[k]    = 1'b0;
    end
    m_credit_exp = '0;
endtask

// relative slot to absolute port, own port skipped
function automatic int abs_port(input int in_port, input int rel);
    return (rel < in_port) ? rel : rel + 1;
endfunction

function automatic int target_ovc(input int k);
    return abs_port(k / router_geom_pkg::num_vcs, m_dest_rel[k]) * router_geom_pkg::num_vcs
           + m_asg_vc[k];
endfunction

function automatic bit ovc_free(input int o);
    return !m_alloc[o] && (m_occ[o] < flow_ctrl_pkg::nearly_full_lvl);
endfunction

function automatic logic [router_geom_pkg::pv-1:0] expected_assigned();
    logic [router_geom_pkg::pv-1:0] r;
    for (int k = 0; k < router_geom_pkg::pv; k++) begin
        r[k] = m_assigned[k];
    end
    return r;
endfunction

function automatic logic [router_geom_pkg::pv-1:0] expected_available();
    logic [router_geom_pkg::pv-1:0] r;
    for (int o = 0; o < router_geom_pkg::pv; o++) begin
        r[o] = ovc_free(o);
    end
    return r;
endfunction

function automatic logic [router_geom_pkg::pv-1:0] expected_not_full();
    logic [router_geom_pkg::pv-1:0] r;
    for (int k = 0; k < router_geom_pkg::pv; k++) begin
        r[k] = m_assigned[k] && (m_occ[target_ovc(k)] < flow_ctrl_pkg::nearly_full_lvl);
    end
    return r;
endfunction

// candidates of waiting input vcs, limited to free vcs at the dest port
function automatic logic [router_geom_pkg::pvv-1:0] expected_request(
    input logic [router_geom_pkg::pv-1:0]  req,
    input logic [router_geom_pkg::pvv-1:0] cand
);
    logic [router_geom_pkg::pvv-1:0] r;
    int o;
    r = '0;
    for (int k = 0; k < router_geom_pkg::pv; k++) begin
        if (req[k] && !m_assigned[k]) begin
            for (int v = 0; v < router_geom_pkg::num_vcs; v++) begin
                o = abs_port(k / router_geom_pkg::num_vcs, m_dest_rel[k])
                    * router_geom_pkg::num_vcs + v;
                r[k*router_geom_pkg::num_vcs + v] =
                    cand[k*router_geom_pkg::num_vcs + v] && ovc_free(o);
            end
        end
    end
    return r;
endfunction

// next state from the inputs of the current cycle
task automatic update_model(
    input logic [router_geom_pkg::pv-1:0]  ovc_grant,
    input logic [router_geom_pkg::pvv-1:0] granted_num,
    input logic [router_geom_pkg::pv-1:0]  sw_grant,
    input logic [router_geom_pkg::pv-1:0]  tail,
    input logic [router_geom_pkg::pv-1:0]  credit,
    input logic [router_geom_pkg::pv-1:0]  allocated
);
    logic [router_geom_pkg::pv-1:0] sent;
    logic [router_geom_pkg::pv-1:0] released;
    sent     = '0;
    released = '0;
    for (int k = 0; k < router_geom_pkg::pv; k++) begin
        if (sw_grant[k]) begin
            sent[target_ovc(k)] = 1'b1;  // uses the vc held before this edge
            if (tail[k]) begin
                released[target_ovc(k)] = 1'b1;
            end
        end
    end
    for (int o = 0; o < router_geom_pkg::pv; o++) begin
        if (sent[o] && !credit[o]) begin
            m_occ[o]++;
        end else if (!sent[o] && credit[o]) begin
            m_occ[o]--;
        end
        m_alloc[o] = (m_alloc[o] || allocated[o]) && !released[o];
    end
    for (int k = 0; k < router_geom_pkg::pv; k++) begin
        for (int v = 0; v < router_geom_pkg::num_vcs; v++) begin
            if (ovc_grant[k] && granted_num[k*router_geom_pkg::num_vcs + v]) begin
                m_asg_vc[k] = v;
            end
        end
        // release beats a grant on the same input vc
        m_assigned[k] = (m_assigned[k] || ovc_grant[k]) && !(sw_grant[k] && tail[k]);
    end
    m_credit_exp = sw_grant;
endtask

function automatic bit model_idle();
    for (int o = 0; o < router_geom_pkg::pv; o++) begin
        if (m_assigned[o] || m_alloc[o] || (m_occ[o] != 0)) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

`endif

//--- tb/tb_vc_port.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vc_port;

    logic                                 clk;
    logic                                 reset;
    logic [router_geom_pkg::pv-1:0]       ivc_num_getting_ovc_grant;
    logic [router_geom_pkg::pvv-1:0]      granted_ovc_num_all;
    logic [router_geom_pkg::pv-1:0]       ivc_num_getting_sw_grant;
    logic [router_geom_pkg::pv-1:0]       ovc_allocated_all;
    logic [router_geom_pkg::pv-1:0]       credit_in_all;
    logic [router_geom_pkg::pv-1:0]       ivc_request_all;
    logic [router_geom_pkg::pv_dst_w-1:0] dest_port_all;
    logic [router_geom_pkg::pvv-1:0]      candidate_ovc_all;
    logic [router_geom_pkg::pv-1:0]       flit_is_tail_all;
    wire  [router_geom_pkg::pv-1:0]       credit_out_all;
    wire  [router_geom_pkg::pv-1:0]       ovc_is_assigned_all;
    wire  [router_geom_pkg::pv-1:0]       assigned_ovc_not_full_all;
    wire  [router_geom_pkg::pv-1:0]       ovc_available_all;
    wire  [router_geom_pkg::pvv-1:0]      masked_ovc_request_all;

    integer seed;

    `include "vc_port_model.svh"

    vc_port_top vc_port_top_inst (
        .clk                       (clk),
        .reset                     (reset),
        .ivc_num_getting_ovc_grant (ivc_num_getting_ovc_grant),
        .granted_ovc_num_all       (granted_ovc_num_all),
        .ivc_num_getting_sw_grant  (ivc_num_getting_sw_grant),
        .ovc_allocated_all         (ovc_allocated_all),
        .credit_in_all             (credit_in_all),
        .ivc_request_all           (ivc_request_all),
        .dest_port_all             (dest_port_all),
        .candidate_ovc_all         (candidate_ovc_all),
        .flit_is_tail_all          (flit_is_tail_all),
        .credit_out_all            (credit_out_all),
        .ovc_is_assigned_all       (ovc_is_assigned_all),
        .assigned_ovc_not_full_all (assigned_ovc_not_full_all),
        .ovc_available_all         (ovc_available_all),
        .masked_ovc_request_all    (masked_ovc_request_all)
    );

    always #4 clk = ~clk;

    // hard limit on the whole run
    initial begin
        #100000;
        $display("timeout: simulation did not reach its end");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // random set bit from a rotating start
    function automatic int pick_one(input logic [router_geom_pkg::num_vcs-1:0] opts);
        int start;
        int v;
        start = rand_below(router_geom_pkg::num_vcs);
        for (int n = 0; n < router_geom_pkg::num_vcs; n++) begin
            v = (start + n) % router_geom_pkg::num_vcs;
            if (opts[v]) begin
                return v;
            end
        end
        return 0;
    endfunction

    task automatic compare_vc_vec(input logic [router_geom_pkg::pv-1:0] got,
                                  input logic [router_geom_pkg::pv-1:0] exp,
                                  input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic compare_vc_req(input logic [router_geom_pkg::pvv-1:0] got,
                                  input logic [router_geom_pkg::pvv-1:0] exp,
                                  input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic drive_stimulus(input bit draining);
        logic [router_geom_pkg::pv-1:0]      claimed;  // output vcs granted this cycle
        logic [router_geom_pkg::pvv-1:0]     req_exp;
        logic [router_geom_pkg::num_vcs-1:0] opts;
        int o;
        int pick;
        claimed                   = '0;
        ivc_num_getting_ovc_grant = '0;
        granted_ovc_num_all       = '0;
        ivc_num_getting_sw_grant  = '0;
        ovc_allocated_all         = '0;
        for (int k = 0; k < router_geom_pkg::pv; k++) begin
            if (!m_assigned[k]) begin  // new packet head may go anywhere
                m_dest_rel[k] = rand_below(router_geom_pkg::dst_w);
                dest_port_all[k*router_geom_pkg::dst_w +: router_geom_pkg::dst_w] = '0;
                dest_port_all[k*router_geom_pkg::dst_w + m_dest_rel[k]] = 1'b1;
                for (int v = 0; v < router_geom_pkg::num_vcs; v++) begin
                    candidate_ovc_all[k*router_geom_pkg::num_vcs + v] = (rand_below(3) != 0);
                end
            end
            ivc_request_all[k]  = !draining && (rand_below(4) != 0);
            flit_is_tail_all[k] = draining || (rand_below(3) == 0);
        end
        req_exp = expected_request(ivc_request_all, candidate_ovc_all);
        for (int k = 0; k < router_geom_pkg::pv; k++) begin
            opts = req_exp[k*router_geom_pkg::num_vcs +: router_geom_pkg::num_vcs];
            if ((opts != '0) && (rand_below(2) == 0)) begin
                pick = pick_one(opts);
                o = abs_port(k / router_geom_pkg::num_vcs, m_dest_rel[k])
                    * router_geom_pkg::num_vcs + pick;
                if (!claimed[o]) begin
                    claimed[o]                   = 1'b1;
                    ivc_num_getting_ovc_grant[k] = 1'b1;
                    granted_ovc_num_all[k*router_geom_pkg::num_vcs + pick] = 1'b1;
                    ovc_allocated_all[o]         = 1'b1;
                end
            end else if (m_assigned[k] && (draining || (rand_below(2) == 0))
                         && (m_occ[target_ovc(k)] < flow_ctrl_pkg::nearly_full_lvl)) begin
                ivc_num_getting_sw_grant[k] = 1'b1;
                // grant landing on a vc whose tail leaves now
                if (flit_is_tail_all[k] && !draining && (rand_below(8) == 0)) begin
                    ivc_num_getting_ovc_grant[k] = 1'b1;
                    granted_ovc_num_all[k*router_geom_pkg::num_vcs + m_asg_vc[k]] = 1'b1;
                end
            end
        end
        for (int c = 0; c < router_geom_pkg::pv; c++) begin
            credit_in_all[c] = (m_occ[c] > 0) && (draining || (rand_below(5) < 2));
        end
    endtask

    task automatic check_outputs();
        compare_vc_vec(credit_out_all, m_credit_exp, "credit_out_all");
        compare_vc_vec(ovc_is_assigned_all, expected_assigned(), "ovc_is_assigned_all");
        compare_vc_vec(ovc_available_all, expected_available(), "ovc_available_all");
        compare_vc_vec(assigned_ovc_not_full_all, expected_not_full(),
                       "assigned_ovc_not_full_all");
        compare_vc_req(masked_ovc_request_all,
                       expected_request(ivc_request_all, candidate_ovc_all),
                       "masked_ovc_request_all");
    endtask

    task automatic run_cycle(input bit draining);
        @(negedge clk);
        drive_stimulus(draining);
        #1;  // combinational outputs settle well before the next rising edge
        check_outputs();
        update_model(ivc_num_getting_ovc_grant, granted_ovc_num_all, ivc_num_getting_sw_grant,
                     flit_is_tail_all, credit_in_all, ovc_allocated_all);
    endtask

    initial begin
        int drain_cycles;
        seed                      = 59285;
        clk                       = 1'b0;
        reset                     = 1'b1;
        ivc_num_getting_ovc_grant = '0;
        granted_ovc_num_all       = '0;
        ivc_num_getting_sw_grant  = '0;
        ovc_allocated_all         = '0;
        credit_in_all             = '0;
        ivc_request_all           = '0;
        dest_port_all             = '0;
        candidate_ovc_all         = '0;
        flit_is_tail_all          = '0;
        reset_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        compare_vc_vec(credit_out_all, '0, "credit_out_all after reset");
        compare_vc_vec(ovc_is_assigned_all, '0, "ovc_is_assigned_all after reset");
        compare_vc_vec(ovc_available_all, '1, "ovc_available_all after reset");
        compare_vc_req(masked_ovc_request_all, '0, "masked_ovc_request_all after reset");

        repeat (2000) begin
            run_cycle(1'b0);
        end

        // release every packet and return all credits
        drain_cycles = 0;
        while (!model_idle()) begin
            run_cycle(1'b1);
            drain_cycles++;
            if (drain_cycles > 200) begin
                $display("timeout: output vcs still busy after %0d drain cycles", drain_cycles);
                $display("SIMULATION FAILED");
                $fatal(1, "drain did not finish");
            end
        end
        run_cycle(1'b1);  // dut state catches up with the idle model

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+tb
rtl/router_geom_pkg.sv
rtl/flow_ctrl_pkg.sv
rtl/ivc_assign_ctrl.sv
rtl/ovc_credit_tracker.sv
rtl/vc_request_mask.sv
rtl/vc_port_top.sv
tb/tb_vc_port.sv

//--- Bender.yml
package:
  name: vc_port

sources:
  - files:
      - rtl/router_geom_pkg.sv
      - rtl/flow_ctrl_pkg.sv
      - rtl/ivc_assign_ctrl.sv
      - rtl/ovc_credit_tracker.sv
      - rtl/vc_request_mask.sv
      - rtl/vc_port_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_vc_port.sv
